// File: design/popcnt_pkg.sv
// Constants and constant functions shared by the population-count RTL
// Supported operand widths run from min_width to max_width
// The functions are meant for elaboration only, to size ports and arrays
// Column k always holds bits of weight 2**k

package popcnt_pkg;

  //////////////////////////////
  // Width limits
  //////////////////////////////

  localparam int min_width = 2;
  localparam int max_width = 64;

  //////////////////////////////
  // Sizing helpers
  //////////////////////////////

  // Bits needed for a count from 0 up to width
  function automatic int count_width_of(input int width);
    return $clog2(width) + 1;
  endfunction

  // n bits need n-1 removals, a full adder removes two of them
  // This is ceil((n - 1) / 2), one carry per adder
  function automatic int column_carries(input int n_bits);
    if (n_bits < 2) begin
      return 0;
    end
    return n_bits / 2;
  endfunction

  // Bits entering column col
  // Column 0 takes the operand, every later column the carries below it
  function automatic int column_bits(input int width, input int col);
    int n;
    n = width;
    for (int i = 0; i < col; i++) begin
      n = column_carries(n);
    end
    return n;
  endfunction

endpackage

// File: design/popcnt_column.sv
// One weight column of the carry-save counting tree
// Purely combinational, no clock and no reset
// N_BITS may be any value from 1 upward
// With a single input bit the carry port is one constant zero bit
// Carries have twice the weight of sum_bit and go to the next column

module popcnt_column import popcnt_pkg::*; #(
  parameter int N_BITS = 3
) (
  input  logic [N_BITS-1:0] bits,
  output logic              sum_bit,
  output logic [((column_carries(N_BITS) > 0) ? column_carries(N_BITS) : 1)-1:0] carries
);

  // Full adders take three bits each, a half adder closes an even column
  localparam int n_fa   = (N_BITS - 1) / 2;
  localparam int n_pool = N_BITS + n_fa;
  localparam bit has_ha = (N_BITS % 2) == 0;

  // Work queue of the column
  // Entries 0..N_BITS-1 are the inputs and each full adder appends its sum
  logic [n_pool-1:0] pool;

  assign pool[N_BITS-1:0] = bits;

  //////////////////////////////
  // Full adder chain
  //////////////////////////////

  // Adder i reads entries 3i..3i+2
  // These are always written before adder i needs them
  for (genvar i = 0; i < n_fa; i++) begin : g_fa
    logic [2:0] fa_in;

    assign fa_in            = pool[3*i +: 3];
    assign pool[N_BITS + i] = ^fa_in;
    assign carries[i]       = (fa_in[0] & fa_in[1]) |
                              (fa_in[0] & fa_in[2]) |
                              (fa_in[1] & fa_in[2]);
  end

  //////////////////////////////
  // Column closure
  //////////////////////////////

  if (has_ha) begin : g_half
    // Two entries left at the end of the queue
    assign sum_bit       = pool[3*n_fa] ^ pool[3*n_fa + 1];
    assign carries[n_fa] = pool[3*n_fa] & pool[3*n_fa + 1];
  end else begin : g_odd
    // One entry left, it is the column's sum
    assign sum_bit = pool[3*n_fa];
  end

  if (N_BITS == 1) begin : g_no_carry
    assign carries = 1'b0;
  end

endmodule

// File: design/popcnt_tree.sv
// Complete carry-save population-count tree
// Purely combinational with zero latency
// WIDTH comes from the top level and must lie in min_width..max_width
// The column count equals the count width
// For widths that are not a power of two the top columns are empty and read 0

module popcnt_tree import popcnt_pkg::*; #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0]                 bits,
  output logic [count_width_of(WIDTH)-1:0] sum
);

  localparam int count_w = count_width_of(WIDTH);

  // Row k holds the bits of weight 2**k
  // Only the low column_bits(WIDTH, k) entries of a row carry data
  logic [count_w-1:0][WIDTH-1:0] col_bits;

  assign col_bits[0] = bits;

  //////////////////////////////
  // Weight columns
  //////////////////////////////

  for (genvar k = 0; k < count_w; k++) begin : g_col
    localparam int n_in  = column_bits(WIDTH, k);
    localparam int n_out = column_carries(n_in);

    if (n_in == 0) begin : g_empty
      // Nothing reaches this weight for the given width
      assign sum[k] = 1'b0;
    end else if (n_in == 1) begin : g_pass
      // Top populated column, its single bit is already the result
      assign sum[k] = col_bits[k][0];
    end else begin : g_reduce
      logic [n_out-1:0] carry_vec;

      popcnt_column #(
        .N_BITS (n_in)
      ) u_column (
        .bits    (col_bits[k][n_in-1:0]),
        .sum_bit (sum[k]),
        .carries (carry_vec)
      );

      // Carries move one weight up
      assign col_bits[k+1][n_out-1:0] = carry_vec;
    end

    // Unused upper entries of the next row are tied low
    if (k < count_w - 1) begin : g_fill
      assign col_bits[k+1][WIDTH-1:n_out] = '0;
    end
  end

endmodule

// File: design/popcnt_unit.sv
// Pipelined population count with a clocked interface
// A one-cycle in_valid strobe loads operand
// count and out_valid follow exactly two cycles later
// A new operand may be strobed every cycle, no back-pressure
// The result is shown for one cycle only, count reads zero otherwise
// WIDTH must lie in min_width..max_width of popcnt_pkg

module popcnt_unit import popcnt_pkg::*; #(
  parameter int WIDTH = 32
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_valid,
  input  logic [WIDTH-1:0]                 operand,
  output logic                             out_valid,
  output logic [count_width_of(WIDTH)-1:0] count
);

  localparam int count_w = count_width_of(WIDTH);

  logic [WIDTH-1:0]   operand_q;
  logic               stage_valid;
  logic [count_w-1:0] tree_sum;

  if (WIDTH < min_width || WIDTH > max_width) begin : g_width_check
    $error("popcnt_unit: WIDTH %0d outside %0d..%0d", WIDTH, min_width, max_width);
  end

  //////////////////////////////
  // Input stage
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      operand_q   <= '0;
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= in_valid;
      // Operand is kept between strobes
      if (in_valid) begin
        operand_q <= operand;
      end
    end
  end

  //////////////////////////////
  // Counting tree
  //////////////////////////////

  popcnt_tree #(
    .WIDTH (WIDTH)
  ) u_tree (
    .bits (operand_q),
    .sum  (tree_sum)
  );

  //////////////////////////////
  // Output stage
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      count     <= '0;
    end else begin
      out_valid <= stage_valid;
      // Zero between results
      if (stage_valid) begin
        count <= tree_sum;
      end else begin
        count <= '0;
      end
    end
  end

endmodule

// File: bench/popcnt_assertions.sv
// Concurrent checks for popcnt_unit, attached to it with bind
// Expected values come from the strobe and operand seen two edges earlier
// fail_count holds the number of failed checks for the closing report
// The checks only run when assertions are enabled at compile time

module popcnt_assertions import popcnt_pkg::*; #(
  parameter int WIDTH = 32
) (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             in_valid,
  input logic [WIDTH-1:0]                 operand,
  input logic                             out_valid,
  input logic [count_width_of(WIDTH)-1:0] count
);

  localparam int count_w = count_width_of(WIDTH);

  int fail_count = 0;

  logic               valid_d1;
  logic               valid_d2;
  logic [WIDTH-1:0]   operand_d1;
  logic [WIDTH-1:0]   operand_d2;
  logic [count_w-1:0] expected_count;

  // Strobe and operand history, two edges deep
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_d1   <= 1'b0;
      valid_d2   <= 1'b0;
      operand_d1 <= '0;
      operand_d2 <= '0;
    end else begin
      valid_d1   <= in_valid;
      valid_d2   <= valid_d1;
      operand_d1 <= operand;
      operand_d2 <= operand_d1;
    end
  end

  // Number of one bits in the operand strobed two edges back
  assign expected_count = count_w'($countones(operand_d2));

  //////////////////////////////
  // Reset behavior
  //////////////////////////////

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (!out_valid && count == '0))
    else begin
      $error("Error out_valid 0x%h count 0x%h during reset, expected 0x0",
             $sampled(out_valid), $sampled(count));
      fail_count++;
    end

  a_first_cycle: assert property (@(posedge clk) $rose(rst_n) |-> (!out_valid && count == '0))
    else begin
      $error("Error out_valid 0x%h count 0x%h after reset, expected 0x0",
             $sampled(out_valid), $sampled(count));
      fail_count++;
    end

  //////////////////////////////
  // Strobe timing
  //////////////////////////////

  a_strobe_timing: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == valid_d2)
    else begin
      $error("Error out_valid expected 0x%h actual 0x%h",
             $sampled(valid_d2), $sampled(out_valid));
      fail_count++;
    end

  // A lone strobe gives a single-cycle pulse
  a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !valid_d1) |=> !out_valid)
    else begin
      $error("Error out_valid expected 0x0 actual 0x%h after a lone strobe",
             $sampled(out_valid));
      fail_count++;
    end

  //////////////////////////////
  // Result value
  //////////////////////////////

  a_count_value: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> count == expected_count)
    else begin
      $error("Error count expected 0x%h actual 0x%h",
             $sampled(expected_count), $sampled(count));
      fail_count++;
    end

endmodule

// File: bench/tb_popcnt.sv
// Testbench for popcnt_unit with a 32-bit operand
// Directed operands come first, then 200 random ones with idle gaps
// Results are checked by the bound popcnt_assertions instance
// Inputs change on the rising clock edge through non-blocking assignments

module tb_popcnt import popcnt_pkg::*; ();

  localparam int width        = 32;
  localparam int count_w      = count_width_of(width);
  localparam int clk_period   = 20;
  localparam int reset_cycles = 16;
  localparam int n_random     = 200;
  localparam int max_gap      = 2;
  localparam int drain_cycles = 8;

  // Directed part with its idle cycles, rounded up
  localparam int directed_cycles = 60;
  localparam int margin_cycles   = 100;
  localparam int timeout_cycles  = reset_cycles + directed_cycles +
                                   n_random * (1 + max_gap) +
                                   drain_cycles + margin_cycles;

  logic               clk;
  logic               rst_n;
  logic               in_valid;
  logic [width-1:0]   operand;
  logic               out_valid;
  logic [count_w-1:0] count;

  int strobes_sent = 0;
  int results_seen = 0;
  int other_errors = 0;

  popcnt_unit #(
    .WIDTH (width)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .operand   (operand),
    .out_valid (out_valid),
    .count     (count)
  );

  bind popcnt_unit popcnt_assertions #(
    .WIDTH (WIDTH)
  ) checks (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .operand   (operand),
    .out_valid (out_valid),
    .count     (count)
  );

  always #(clk_period / 2) clk = ~clk;

  // Results leaving the pipeline
  always @(posedge clk) begin
    if (rst_n && out_valid) begin
      results_seen <= results_seen + 1;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [width-1:0] random_operand();
    logic [63:0] raw;
    raw = {$urandom, $urandom};
    return width'(raw);
  endfunction

  task automatic strobe(input logic [width-1:0] value);
    @(posedge clk);
    in_valid <= 1'b1;
    operand  <= value;
    strobes_sent++;
  endtask

  // Operand carries junk between strobes
  task automatic idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      in_valid <= 1'b0;
      operand  <= random_operand();
    end
  endtask

  task automatic directed_phase();
    // Lone strobes with the extremes
    strobe('0);
    idle(3);
    strobe('1);
    idle(3);
    // Single bits at both ends
    strobe(width'(1));
    idle(1);
    strobe({1'b1, {(width-1){1'b0}}});
    idle(2);
    // Back to back with two operands in flight
    strobe('1);
    strobe('0);
    strobe({(width/2){2'b01}});
    strobe({(width/2){2'b10}});
    strobe({{(width/2){1'b0}}, {(width/2){1'b1}}});
    strobe({{(width/2){1'b1}}, {(width/2){1'b0}}});
    strobe({1'b0, {(width-1){1'b1}}});
    strobe('1);
    idle(4);
  endtask

  task automatic random_phase();
    logic [width-1:0] value;
    int               mode;
    int               gap_draw;
    for (int i = 0; i < n_random; i++) begin
      mode = $urandom_range(0, 3);
      case (mode)
        0:       value = random_operand() & random_operand();
        1:       value = random_operand() | random_operand();
        default: value = random_operand();
      endcase
      strobe(value);
      // Half of the strobes run back to back
      gap_draw = $urandom_range(0, 3);
      if (gap_draw >= 2) begin
        idle(gap_draw - 1);
      end
    end
  endtask

  task automatic print_summary();
    int failures;
    failures = dut0.checks.fail_count;
    if (results_seen != strobes_sent) begin
      $display("Result count differs: %0d operands strobed, %0d results seen",
               strobes_sent, results_seen);
      other_errors++;
    end
    $display("Summary: %0d strobes, %0d results, %0d assertion failures, %0d other errors",
             strobes_sent, results_seen, failures, other_errors);
    if (failures == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    operand  = '0;
    void'($urandom(53));
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    directed_phase();
    random_phase();
    idle(drain_cycles);
    print_summary();
  end

  // Watchdog
  initial begin
    #(timeout_cycles * clk_period);
    $display("Timeout: the run did not finish within %0d cycles, %0d strobes, %0d results",
             timeout_cycles, strobes_sent, results_seen);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: project.f
design/popcnt_pkg.sv
design/popcnt_column.sv
design/popcnt_tree.sv
design/popcnt_unit.sv
bench/popcnt_assertions.sv
bench/tb_popcnt.sv

// File: run.sh
#!/bin/sh
# Builds tb_popcnt with Verilator and runs it
# The run counts as passed only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_popcnt \
  -f project.f \
  -o sim_popcnt \
  || { echo "Verilator build failed"; exit 1; }

# A high error limit keeps failed checks from stopping the run early
sim_out=$(./obj_dir/sim_popcnt +verilator+error+limit+100000)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -q "^Simulation passed$" \
  && exit 0 \
  || exit 1
